//--- verilog/aes_ctrl_defines.svh
// Timing constants for the serial AES sequencer; the decoder assumes SBOX_LAT and SERIAL_LAT stay 4
`ifndef AES_CTRL_DEFINES_SVH
`define AES_CTRL_DEFINES_SVH

// S-box pipeline depth in cycles
`define SBOX_LAT 4

// One 128-bit state streamed as four 32-bit columns
`define SERIAL_LAT 4

// Cycles spent in every full or last round
`define ROUND_CYCLES (`SBOX_LAT + `SERIAL_LAT)

// Cycle counter must hold ROUND_CYCLES - 1
`define CNT_W 5

// Round counter must hold the round count of AES-256
`define ROUND_W 4

// Round index of the last full round, AES-128 and AES-256
`define LIMIT_128 8
`define LIMIT_256 12

`endif

//--- verilog/aes_ctrl_pkg.sv
// Shared types of the AES sequencer; field order of the control words is fixed by the datapath
package aes_ctrl_pkg;

    `include "aes_ctrl_defines.svh"

    // Job configuration, sampled at job start
    typedef struct packed {
        logic inverse;
        logic mode_256;
    } exec_cfg_t;

    // Sequencer phases
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_FIRST_SBK,
        PH_ROUND,
        PH_LAST_ROUND,
        PH_AK_FINAL
    } phase_t;

    // Position of the running job
    typedef struct packed {
        phase_t               phase;
        logic [`CNT_W-1:0]    cnt;
        logic [`ROUND_W-1:0]  round;
        logic                 last_full_round;
    } seq_status_t;

    // State holder controls
    typedef struct packed {
        logic init;
        logic enable;
        logic en_mc;
        logic en_loop;
        logic en_loop_r0;
        logic en_sb_inverse;
        logic bypass_mc_inverse;
        logic en_to_sb_inverse;
    } state_ctrl_t;

    // Key holder controls
    typedef struct packed {
        logic init;
        logic enable;
        logic loop;
        logic add_from_sb;
        logic rst_buffer_from_sbox;
        logic last_key_pre_valid;
        logic disable_rot_rcon;
        logic enable_pipe_high;
        logic feedback_from_high;
        logic col7_to_sb;
    } key_ctrl_t;

    // Round-constant unit controls
    typedef struct packed {
        logic rst;
        logic mode_256;
        logic update;
        logic inverse;
    } rcon_ctrl_t;

    // S-box and its input mux
    typedef struct packed {
        logic valid_in;
        logic inverse;
        logic feed_key;
        logic key_add;
        logic key_add_inverse;
    } sbox_ctrl_t;

endpackage

//--- verilog/aes_ctrl_accept.sv
// Input side expects valid_in, inverse and mode_256 held stable until in_ready is seen high
`timescale 1ns/100ps

module aes_ctrl_accept (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     valid_in,
    input  logic                     inverse,
    input  logic                     mode_256,
    input  logic                     out_ready,
    input  logic                     idle,
    input  logic                     done,
    output logic                     in_ready,
    output logic                     out_valid,
    output logic                     start,
    output logic                     flush,
    output aes_ctrl_pkg::exec_cfg_t  cfg
);

    import aes_ctrl_pkg::*;

    logic      in_ready_q;
    logic      out_valid_q;
    logic      fetch;
    logic      slot_free;
    exec_cfg_t cfg_live;
    exec_cfg_t cfg_q;

    // Result taken by the consumer this cycle
    assign fetch     = out_valid_q & out_ready;
    assign slot_free = ~out_valid_q | out_ready;

    // Start only with in_ready high so the transfer completes in the start cycle
    assign start = idle & valid_in & in_ready_q & slot_free;
    // Nothing to run and nothing held, keep the datapath cleared
    assign flush = idle & slot_free & ~start;

    assign cfg_live.inverse  = inverse;
    assign cfg_live.mode_256 = mode_256;

    // Live inputs in the start cycle, saved copy for the rest of the job
    assign cfg = start ? cfg_live : cfg_q;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            cfg_q <= '0;
        end else if (start) begin
            cfg_q <= cfg_live;
        end
    end

    // Result flag, set after the last final key addition cycle
    always_ff @(posedge clk) begin
        if (rst || fetch) begin
            out_valid_q <= 1'b0;
        end else if (done) begin
            out_valid_q <= 1'b1;
        end
    end

    // Registered ready, high only while idle with an empty result slot
    always_ff @(posedge clk) begin
        if (rst) begin
            in_ready_q <= 1'b1;
        end else begin
            in_ready_q <= idle & slot_free & ~start;
        end
    end

    assign in_ready  = in_ready_q;
    assign out_valid = out_valid_q;

endmodule

//--- verilog/aes_ctrl_sequencer.sv
// Phase FSM for AES-128 and AES-256 only; start is taken only in the idle phase
`timescale 1ns/100ps

`include "aes_ctrl_defines.svh"

module aes_ctrl_sequencer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  aes_ctrl_pkg::exec_cfg_t    cfg,
    output aes_ctrl_pkg::seq_status_t  status,
    output logic                       idle,
    output logic                       done
);

    import aes_ctrl_pkg::*;

    localparam logic [`CNT_W-1:0] LAST_RND_CYC = `CNT_W'(`ROUND_CYCLES - 1);
    localparam logic [`CNT_W-1:0] LAST_AK_CYC  = `CNT_W'(`SERIAL_LAT - 1);

    phase_t              phase_q;
    phase_t              phase_d;
    logic [`CNT_W-1:0]   cnt_q;
    logic [`ROUND_W-1:0] round_q;
    logic [`ROUND_W-1:0] limit_q;
    logic                cnt_clr;
    logic                cnt_inc;
    logic                round_clr;
    logic                round_inc;
    logic                limit_load;
    logic                last_rnd_cyc;
    logic                last_full_round;

    assign last_rnd_cyc    = (cnt_q == LAST_RND_CYC);
    assign last_full_round = (round_q == limit_q);

    // Final key addition ends the job
    assign done = (phase_q == PH_AK_FINAL) && (cnt_q == LAST_AK_CYC);
    assign idle = (phase_q == PH_IDLE);

    always_comb begin
        phase_d    = phase_q;
        cnt_clr    = 1'b0;
        cnt_inc    = 1'b0;
        round_clr  = 1'b0;
        round_inc  = 1'b0;
        limit_load = 1'b0;
        case (phase_q)
            PH_IDLE: begin
                if (start) begin
                    phase_d   = PH_FIRST_SBK;
                    cnt_clr   = 1'b1;
                    round_clr = 1'b1;
                end
            end
            // Single cycle, last key column goes to the S-box
            PH_FIRST_SBK: begin
                limit_load = 1'b1;
                cnt_clr    = 1'b1;
                phase_d    = PH_ROUND;
            end
            PH_ROUND: begin
                if (last_rnd_cyc) begin
                    cnt_clr   = 1'b1;
                    round_inc = 1'b1;
                    phase_d   = last_full_round ? PH_LAST_ROUND : PH_ROUND;
                end else begin
                    cnt_inc = 1'b1;
                end
            end
            PH_LAST_ROUND: begin
                if (last_rnd_cyc) begin
                    cnt_clr   = 1'b1;
                    round_inc = 1'b1;
                    phase_d   = PH_AK_FINAL;
                end else begin
                    cnt_inc = 1'b1;
                end
            end
            PH_AK_FINAL: begin
                if (done) begin
                    cnt_clr = 1'b1;
                    phase_d = PH_IDLE;
                end else begin
                    cnt_inc = 1'b1;
                end
            end
            default: phase_d = PH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q <= PH_IDLE;
            cnt_q   <= '0;
            round_q <= '0;
            limit_q <= `ROUND_W'(`LIMIT_128);
        end else begin
            phase_q <= phase_d;
            // Cycle position inside the phase
            if (cnt_clr) begin
                cnt_q <= '0;
            end else if (cnt_inc) begin
                cnt_q <= cnt_q + 1'b1;
            end
            if (round_clr) begin
                round_q <= '0;
            end else if (round_inc) begin
                round_q <= round_q + 1'b1;
            end
            // Saved configuration is valid from the first phase on
            if (limit_load) begin
                limit_q <= cfg.mode_256 ? `ROUND_W'(`LIMIT_256) : `ROUND_W'(`LIMIT_128);
            end
        end
    end

    assign status.phase           = phase_q;
    assign status.cnt             = cnt_q;
    assign status.round           = round_q;
    assign status.last_full_round = last_full_round;

endmodule

//--- verilog/aes_ctrl_decode.sv
// Combinational control decode; cycle windows assume an S-box latency of 4 and 32-bit columns
`timescale 1ns/100ps

`include "aes_ctrl_defines.svh"

module aes_ctrl_decode (
    input  aes_ctrl_pkg::seq_status_t  status,
    input  aes_ctrl_pkg::exec_cfg_t    cfg,
    input  logic                       start,
    input  logic                       flush,
    output aes_ctrl_pkg::state_ctrl_t  state_ctrl,
    output aes_ctrl_pkg::key_ctrl_t    key_ctrl,
    output aes_ctrl_pkg::rcon_ctrl_t   rcon_ctrl,
    output aes_ctrl_pkg::sbox_ctrl_t   sbox_ctrl
);

    import aes_ctrl_pkg::*;

    localparam logic [`CNT_W-1:0] LAST_RND_CYC = `CNT_W'(`ROUND_CYCLES - 1);
    localparam logic [`CNT_W-1:0] SERIAL_END   = `CNT_W'(`SERIAL_LAT);
    localparam logic [`CNT_W-1:0] KEXP_FIRST   = `CNT_W'(`SBOX_LAT - 1);
    localparam logic [`CNT_W-1:0] KEXP_END     = `CNT_W'(`SBOX_LAT - 1 + `SERIAL_LAT);
    localparam logic [`CNT_W-1:0] KUPD_END     = `CNT_W'(`SBOX_LAT + 3);
    localparam logic [`CNT_W-1:0] SHIFT_END    = `CNT_W'(`SBOX_LAT + `SERIAL_LAT);

    logic in_first;
    logic in_round;
    logic in_last;
    logic in_rounds;
    logic in_akf;
    logic last_cyc;
    logic in_aksb;
    logic in_aksb_ex_last;
    logic in_kexp;
    logic kexp_first;
    logic in_key_update;
    logic in_key_shift;
    logic ak_phase;
    logic first_round;
    logic round_odd;
    logic inv;
    logic m256;
    logic feed_key;

    assign in_first  = (status.phase == PH_FIRST_SBK);
    assign in_round  = (status.phase == PH_ROUND);
    assign in_last   = (status.phase == PH_LAST_ROUND);
    assign in_akf    = (status.phase == PH_AK_FINAL);
    assign in_rounds = in_round | in_last;

    // Cycle windows inside a round
    assign last_cyc        = (status.cnt == LAST_RND_CYC);
    assign in_aksb         = (status.cnt < SERIAL_END);
    assign in_aksb_ex_last = (status.cnt < SERIAL_END - 1'b1);
    // Key expansion starts when the key column returns from the S-box
    assign kexp_first      = (status.cnt == KEXP_FIRST);
    assign in_kexp         = (status.cnt >= KEXP_FIRST) && (status.cnt < KEXP_END);
    assign in_key_update   = (status.cnt >= KEXP_FIRST) && (status.cnt < KUPD_END);
    assign in_key_shift    = (status.cnt > KEXP_FIRST) && (status.cnt < SHIFT_END);

    assign first_round = (status.round == '0);
    assign round_odd   = status.round[0];
    assign inv         = cfg.inverse;
    assign m256        = cfg.mode_256;

    // Key addition window, rounds and final addition
    assign ak_phase = (in_rounds & in_aksb) | in_akf;

    // Key material goes to the S-box in the first cycle and closing round cycles
    assign feed_key = in_first | (in_rounds & last_cyc);

    // State holder
    assign state_ctrl.init              = start | flush;
    // Held while the S-box returns key material
    assign state_ctrl.enable            = start | flush | in_akf | (in_rounds & ~kexp_first);
    assign state_ctrl.en_mc             = ~inv & in_round;
    // Decryption keeps the lower rows looping all the time
    assign state_ctrl.en_loop           = inv | ak_phase;
    assign state_ctrl.en_loop_r0        = ak_phase;
    assign state_ctrl.en_sb_inverse     = inv & in_rounds & ~in_aksb;
    assign state_ctrl.bypass_mc_inverse = inv & in_round & in_aksb & first_round;
    assign state_ctrl.en_to_sb_inverse  = inv;

    // Key holder, lower columns
    assign key_ctrl.init   = start | flush;
    assign key_ctrl.enable = start | flush | in_akf | in_first
                           | (in_rounds & (in_aksb_ex_last | last_cyc | in_kexp));

    always_comb begin
        key_ctrl.loop = 1'b0;
        if (in_akf || in_first) begin
            key_ctrl.loop = 1'b1;
        end else if (in_round) begin
            key_ctrl.loop = in_aksb_ex_last | last_cyc;
        end else if (in_last) begin
            // AES-256 keeps the previous key material through the last round
            key_ctrl.loop = m256 | in_aksb_ex_last | last_cyc;
        end
    end

    assign key_ctrl.add_from_sb          = in_rounds & kexp_first;
    // Temporary key buffer only runs in decryption key updates
    assign key_ctrl.rst_buffer_from_sbox = ~(inv & in_rounds & in_key_update);
    assign key_ctrl.last_key_pre_valid   = ~inv & in_last & last_cyc;
    assign key_ctrl.disable_rot_rcon     = m256 & in_rounds & round_odd;
    // Upper columns only exist in AES-256
    assign key_ctrl.enable_pipe_high     = m256 & (start | (in_rounds & in_key_shift));
    assign key_ctrl.feedback_from_high   = m256 & in_rounds & in_key_shift;
    assign key_ctrl.col7_to_sb           = m256 & in_first;

    // Round constant
    assign rcon_ctrl.rst      = in_first;
    assign rcon_ctrl.mode_256 = m256;
    assign rcon_ctrl.inverse  = inv;
    // AES-256 steps on odd rounds in encryption, even rounds in decryption
    assign rcon_ctrl.update   = in_round & last_cyc & (~m256 | (round_odd ^ inv));

    // S-box
    assign sbox_ctrl.valid_in        = in_first | (in_rounds & in_aksb) | (in_round & last_cyc);
    assign sbox_ctrl.feed_key        = feed_key;
    assign sbox_ctrl.inverse         = inv & ~feed_key;
    assign sbox_ctrl.key_add         = ak_phase & ~inv;
    assign sbox_ctrl.key_add_inverse = ak_phase & inv;

endmodule

//--- verilog/aes_ctrl_top.sv
// Sequencer top; drives controls only, the AES datapath sits outside and follows these words
`timescale 1ns/100ps

module aes_ctrl_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       valid_in,
    input  logic                       inverse,
    input  logic                       mode_256,
    input  logic                       out_ready,
    output logic                       in_ready,
    output logic                       out_valid,
    output logic                       busy,
    output aes_ctrl_pkg::state_ctrl_t  state_ctrl,
    output aes_ctrl_pkg::key_ctrl_t    key_ctrl,
    output aes_ctrl_pkg::rcon_ctrl_t   rcon_ctrl,
    output aes_ctrl_pkg::sbox_ctrl_t   sbox_ctrl
);

    import aes_ctrl_pkg::*;

    logic        start;
    logic        flush;
    logic        idle;
    logic        done;
    exec_cfg_t   cfg;
    seq_status_t status;

    // Handshake, job configuration and result flag
    aes_ctrl_accept u_accept (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .inverse   (inverse),
        .mode_256  (mode_256),
        .out_ready (out_ready),
        .idle      (idle),
        .done      (done),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .start     (start),
        .flush     (flush),
        .cfg       (cfg)
    );

    aes_ctrl_sequencer u_sequencer (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .cfg    (cfg),
        .status (status),
        .idle   (idle),
        .done   (done)
    );

    // Datapath control words
    aes_ctrl_decode u_decode (
        .status     (status),
        .cfg        (cfg),
        .start      (start),
        .flush      (flush),
        .state_ctrl (state_ctrl),
        .key_ctrl   (key_ctrl),
        .rcon_ctrl  (rcon_ctrl),
        .sbox_ctrl  (sbox_ctrl)
    );

    assign busy = ~idle;

endmodule

//--- sim/aes_ctrl_clkgen.sv
// Free-running 20 ns clock; rst stays high for the first 4 rising edges, then drops 2 ns later
`timescale 1ns/100ps

module aes_ctrl_clkgen (
    output logic clk,
    output logic rst
);

    // Half period of 10 ns
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Released with the same 2 ns skew as the other inputs
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

//--- sim/aes_ctrl_assert.sv
// Bound into aes_ctrl_top; rules are not checked while rst is high
`timescale 1ns/100ps

module aes_ctrl_assert (
    input logic                      clk,
    input logic                      rst,
    input logic                      busy,
    input logic                      in_ready,
    input logic                      out_valid,
    input logic                      out_ready,
    input aes_ctrl_pkg::sbox_ctrl_t  sbox_ctrl
);

    // Number of failed assertion checks
    int failures = 0;

    // Registered ready stays low for the whole job
    busy_blocks_ready: assert property (@(posedge clk) disable iff (rst) busy |-> !in_ready)
        else begin
            failures++;
            $error("in_ready high while the sequencer is busy");
        end

    // Result is held until the consumer takes it
    result_held: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid)
        else begin
            failures++;
            $error("out_valid dropped without out_ready");
        end

    // Only one key addition direction at a time
    one_key_add: assert property (@(posedge clk) disable iff (rst)
        !(sbox_ctrl.key_add && sbox_ctrl.key_add_inverse))
        else begin
            failures++;
            $error("key_add and key_add_inverse both high");
        end

    // Key material always takes the forward S-box
    key_not_inverse: assert property (@(posedge clk) disable iff (rst)
        sbox_ctrl.inverse |-> !sbox_ctrl.feed_key)
        else begin
            failures++;
            $error("sbox inverse high while key is fed to the S-box");
        end

endmodule

//--- sim/aes_ctrl_tb.sv
// Reads sim/aes_ctrl_patterns.txt relative to the project root; expected counts come from that file
`timescale 1ns/100ps

module aes_ctrl_tb;

    import aes_ctrl_pkg::*;

    localparam int NUM_JOBS       = 8;
    localparam int PAT_COLS       = 8;
    localparam int TIMEOUT_CYCLES = NUM_JOBS * 200;

    logic        clk;
    logic        rst;
    logic        valid_in;
    logic        inverse;
    logic        mode_256;
    logic        out_ready;
    logic        in_ready;
    logic        out_valid;
    logic        busy;
    state_ctrl_t state_ctrl;
    key_ctrl_t   key_ctrl;
    rcon_ctrl_t  rcon_ctrl;
    sbox_ctrl_t  sbox_ctrl;

    // Eight bytes per job in the column order of the pattern file
    logic [7:0]  patterns [0:NUM_JOBS*PAT_COLS-1];
    int          errors;
    int          jobs_done;
    int          cycles = 0;
    int          j;
    int          s;
    int          gap;
    int          lat;
    int          n_sbox;
    int          n_kadd;
    int          n_kadd_other;
    int          n_mc;
    int          n_rcon;
    int          cur_stall;
    logic        cur_m256;
    logic        cur_inv;

    aes_ctrl_clkgen clkgen0 (
        .clk (clk),
        .rst (rst)
    );

    aes_ctrl_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .valid_in   (valid_in),
        .inverse    (inverse),
        .mode_256   (mode_256),
        .out_ready  (out_ready),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .busy       (busy),
        .state_ctrl (state_ctrl),
        .key_ctrl   (key_ctrl),
        .rcon_ctrl  (rcon_ctrl),
        .sbox_ctrl  (sbox_ctrl)
    );

    bind aes_ctrl_top aes_ctrl_assert u_assert (
        .clk       (clk),
        .rst       (rst),
        .busy      (busy),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .sbox_ctrl (sbox_ctrl)
    );

    function automatic int pattern_field(input int job, input int col);
        return int'(patterns[job*PAT_COLS+col]);
    endfunction

    task automatic report_mismatch(input string name, input int got, input int exp);
        errors++;
        $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic next_edge();
        @(posedge clk);
        #2;
    endtask

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run stopped, jobs did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("Jobs run: %0d, errors: %0d", jobs_done, errors + 1);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        valid_in  = 1'b0;
        inverse   = 1'b0;
        mode_256  = 1'b0;
        out_ready = 1'b1;
        errors    = 0;
        jobs_done = 0;
        void'($urandom(32'h297be8e7));
        $readmemh("sim/aes_ctrl_patterns.txt", patterns);

        @(negedge rst);
        @(negedge clk);
        // Idle after reset with the datapath being flushed
        if (in_ready !== 1'b1) report_mismatch("in_ready", in_ready, 1);
        if (out_valid !== 1'b0) report_mismatch("out_valid", out_valid, 0);
        if (busy !== 1'b0) report_mismatch("busy", busy, 0);
        if (sbox_ctrl.valid_in !== 1'b0) report_mismatch("sbox.valid_in", sbox_ctrl.valid_in, 0);
        if (rcon_ctrl.update !== 1'b0) report_mismatch("rcon.update", rcon_ctrl.update, 0);
        if (state_ctrl.en_mc !== 1'b0) report_mismatch("state.en_mc", state_ctrl.en_mc, 0);
        if (state_ctrl.init !== 1'b1) report_mismatch("state.init", state_ctrl.init, 1);
        if (key_ctrl.init !== 1'b1) report_mismatch("key.init", key_ctrl.init, 1);

        next_edge();
        out_ready = (pattern_field(0, 2) == 0);

        for (j = 0; j < NUM_JOBS; j++) begin
            cur_m256  = (pattern_field(j, 0) != 0);
            cur_inv   = (pattern_field(j, 1) != 0);
            cur_stall = pattern_field(j, 2);
            // Request may already be up from the previous stall
            if (!valid_in) begin
                gap = int'($urandom % 4);
                repeat (gap) next_edge();
                valid_in = 1'b1;
                mode_256 = cur_m256;
                inverse  = cur_inv;
            end

            // Sticky request waits for the registered ready
            @(negedge clk);
            while (!in_ready) @(negedge clk);
            if (out_valid !== 1'b0) report_mismatch("out_valid", out_valid, 0);
            next_edge();
            valid_in     = 1'b0;
            lat          = 0;
            n_sbox       = 0;
            n_kadd       = 0;
            n_kadd_other = 0;
            n_mc         = 0;
            n_rcon       = 0;

            // Count control events until the result shows up
            @(negedge clk);
            while (!out_valid) begin
                if (busy) lat++;
                if (sbox_ctrl.valid_in) n_sbox++;
                if (cur_inv ? sbox_ctrl.key_add_inverse : sbox_ctrl.key_add) n_kadd++;
                if (cur_inv ? sbox_ctrl.key_add : sbox_ctrl.key_add_inverse) n_kadd_other++;
                if (state_ctrl.en_mc) n_mc++;
                if (rcon_ctrl.update) n_rcon++;
                @(negedge clk);
            end
            if (lat != pattern_field(j, 3)) report_mismatch("latency", lat, pattern_field(j, 3));
            if (busy !== 1'b0) report_mismatch("busy", busy, 0);
            if (n_sbox != pattern_field(j, 4)) report_mismatch("sbox.valid_in count", n_sbox,
                pattern_field(j, 4));
            if (n_kadd != pattern_field(j, 5)) report_mismatch("key add count", n_kadd,
                pattern_field(j, 5));
            if (n_kadd_other != 0) report_mismatch("other key add count", n_kadd_other, 0);
            if (n_mc != pattern_field(j, 6)) report_mismatch("state.en_mc count", n_mc,
                pattern_field(j, 6));
            if (n_rcon != pattern_field(j, 7)) report_mismatch("rcon.update count", n_rcon,
                pattern_field(j, 7));

            // Under back-pressure the result waits and nothing new may start
            for (s = 0; s < cur_stall; s++) begin
                next_edge();
                if (s == 0 && j + 1 < NUM_JOBS) begin
                    valid_in = 1'b1;
                    mode_256 = (pattern_field(j + 1, 0) != 0);
                    inverse  = (pattern_field(j + 1, 1) != 0);
                end
                @(negedge clk);
                if (out_valid !== 1'b1) report_mismatch("out_valid", out_valid, 1);
                if (busy !== 1'b0) report_mismatch("busy", busy, 0);
                if (in_ready !== 1'b0) report_mismatch("in_ready", in_ready, 0);
            end
            if (cur_stall > 0) begin
                next_edge();
                out_ready = 1'b1;
            end
            // Result taken at this edge
            next_edge();
            jobs_done++;
            if (j + 1 < NUM_JOBS) out_ready = (pattern_field(j + 1, 2) == 0);
        end

        @(negedge clk);
        if (out_valid !== 1'b0) report_mismatch("out_valid", out_valid, 0);
        errors += dut0.u_assert.failures;
        $display("Jobs run: %0d, errors: %0d", jobs_done, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sim/aes_ctrl_patterns.txt
// Columns in hex: mode_256 inverse stall latency sbox_valid key_add en_mc rcon_update
// One job per line, counts taken over the busy cycles of that job
00 00 00 55 32 2c 48 09
00 01 03 55 32 2c 00 09
01 00 00 75 46 3c 68 06
01 01 05 75 46 3c 00 07
00 00 0a 55 32 2c 48 09
01 00 02 75 46 3c 68 06
01 01 00 75 46 3c 00 07
00 01 07 55 32 2c 00 09

//--- project.f
+incdir+verilog
verilog/aes_ctrl_pkg.sv
verilog/aes_ctrl_accept.sv
verilog/aes_ctrl_sequencer.sv
verilog/aes_ctrl_decode.sv
verilog/aes_ctrl_top.sv
sim/aes_ctrl_clkgen.sv
sim/aes_ctrl_assert.sv
sim/aes_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the sequencer testbench with Verilator from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module aes_ctrl_tb -f project.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vaes_ctrl_tb +verilator+error+limit+100 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
